/* source/display_consts.svh */
`ifndef DISPLAY_CONSTS_SVH
`define DISPLAY_CONSTS_SVH

// Raster sizes of the 640x480 mode.
`define H_ACTIVE 640
`define H_TOTAL 800
`define V_ACTIVE 480
`define V_TOTAL 525

// Sync pulse positions. The first value is inclusive and the second exclusive.
`define H_SYNC_START 656
`define H_SYNC_END 752
`define V_SYNC_START 490
`define V_SYNC_END 492

// One memory word carries sixteen 8-bit palette indices.
`define WORDS_PER_LINE 40
`define PIXELS_PER_WORD 16

// Word addresses of the two frame images.
`define FRAME_BASE_A 22'h100000
`define FRAME_BASE_B 22'h200000

// Cycles from draw coordinates to the matching RGB.
`define PIPE_DELAY 2

`endif

/* source/display_pkg.sv */
package display_pkg;

  // States of the scanline fetcher.
  typedef enum logic [1:0] {
    fetch_idle,
    fetch_request,
    fetch_store,
    fetch_hold
  } fetch_state_t;

  // Byte k holds the palette index of pixel k within the word.
  typedef logic [127:0] mem_word_t;

endpackage

/* source/video_timing.sv */
`timescale 1ns/1ps
`include "display_consts.svh"

module video_timing (
  input  logic       clock,
  input  logic       reset,
  output logic [9:0] draw_x,
  output logic [9:0] draw_y,
  output logic       active,
  output logic       new_frame,
  output logic       hsync_raw,
  output logic       vsync_raw
);

  logic line_end;
  logic frame_end;

  assign line_end  = (draw_x == 10'(`H_TOTAL - 1));
  assign frame_end = (draw_y == 10'(`V_TOTAL - 1));

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      draw_x <= '0;
      draw_y <= '0;
    end
    else
    begin
      if (line_end)
      begin
        draw_x <= '0;
        if (frame_end)
          draw_y <= '0;
        else
          draw_y <= draw_y + 10'd1;
      end
      else
      begin
        draw_x <= draw_x + 10'd1;
      end
    end
  end

  assign active = (draw_x < 10'(`H_ACTIVE)) && (draw_y < 10'(`V_ACTIVE));

  // Both syncs are active low.
  assign hsync_raw = !((draw_x >= 10'(`H_SYNC_START)) && (draw_x < 10'(`H_SYNC_END)));
  assign vsync_raw = !((draw_y >= 10'(`V_SYNC_START)) && (draw_y < 10'(`V_SYNC_END)));

  // Fires once per frame, on the first pixel after the last visible line.
  assign new_frame = (draw_x == 10'd0) && (draw_y == 10'(`V_ACTIVE));

endmodule

/* source/scanline_fetch.sv */
`timescale 1ns/1ps
`include "display_consts.svh"

module scanline_fetch (
  input  logic                   clock,
  input  logic                   reset,
  input  logic [9:0]             draw_x,
  input  logic [9:0]             draw_y,
  input  logic                   new_frame,
  output logic                   mem_read,
  output logic [21:0]            mem_address,
  input  display_pkg::mem_word_t mem_data,
  input  logic                   mem_ack,
  input  logic                   mem_wait,
  output display_pkg::mem_word_t line_word
);

  import display_pkg::*;

  localparam int BUFFER_DEPTH = 2 * `WORDS_PER_LINE;

  fetch_state_t state;
  fetch_state_t next_state;
  logic [9:0]   next_line;
  logic [9:0]   fetch_line;
  logic [5:0]   word_count;
  logic [5:0]   read_word;
  logic [6:0]   write_index;
  logic [6:0]   read_index;
  logic [21:0]  frame_base;
  logic         frame_b;
  logic         start_fetch;
  logic         last_word;
  mem_word_t    store_word;
  mem_word_t    line_buffer [BUFFER_DEPTH];

  // Line 0 of the next frame is fetched during the last blank line.
  assign next_line = (draw_y == 10'(`V_TOTAL - 1)) ? 10'd0 : draw_y + 10'd1;

  assign start_fetch = (state == fetch_idle) && (draw_x == 10'd0)
                       && (next_line < 10'(`V_ACTIVE));
  assign last_word = (word_count == 6'(`WORDS_PER_LINE - 1));

  always_comb
  begin
    next_state = state;
    case (state)
      fetch_idle:
        if (start_fetch)
          next_state = mem_wait ? fetch_hold : fetch_request;
      fetch_hold:
        if (!mem_wait)
          next_state = fetch_request;
      fetch_request:
        if (mem_ack)
          next_state = fetch_store;
      fetch_store:
        if (last_word)
          next_state = fetch_idle;
        else if (mem_wait)
          next_state = fetch_hold; // Wait again before raising the next read.
        else
          next_state = fetch_request;
      default:
        next_state = fetch_idle;
    endcase
  end

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      state      <= fetch_idle;
      fetch_line <= '0;
      word_count <= '0;
      frame_b    <= 1'b0;
    end
    else
    begin
      state <= next_state;
      if (new_frame)
        frame_b <= !frame_b; // The image just shown becomes free for redrawing.
      if (start_fetch)
      begin
        fetch_line <= next_line;
        word_count <= '0;
      end
      else if (state == fetch_store)
      begin
        word_count <= word_count + 6'd1;
      end
    end
  end

  assign frame_base  = frame_b ? `FRAME_BASE_B : `FRAME_BASE_A;
  assign mem_address = frame_base + 22'(fetch_line) * 22'(`WORDS_PER_LINE)
                       + 22'(word_count);
  assign mem_read    = (state == fetch_request);

  // Line L lives in half L[0], so the half on screen is never overwritten.
  assign write_index = fetch_line[0] ? 7'(`WORDS_PER_LINE) + 7'(word_count)
                                     : 7'(word_count);

  // Past the visible width the index would leave the buffer.
  assign read_word  = (draw_x < 10'(`H_ACTIVE)) ? 6'(draw_x / 10'(`PIXELS_PER_WORD)) : 6'd0;
  assign read_index = draw_y[0] ? 7'(`WORDS_PER_LINE) + 7'(read_word) : 7'(read_word);

  always_ff @(posedge clock)
  begin
    if ((state == fetch_request) && mem_ack)
      store_word <= mem_data; // Data is valid only in the acknowledge cycle.
    if (state == fetch_store)
      line_buffer[write_index] <= store_word;
    line_word <= line_buffer[read_index];
  end

  // A read starts only after the memory has been free in the cycle before.
  a_read_rise: assert property (@(posedge clock) disable iff (reset)
    $rose(mem_read) |-> !$past(mem_wait));

  // No word is stored past the end of a line, which keeps the counter at 40 or below.
  a_word_count: assert property (@(posedge clock) disable iff (reset)
    (state == fetch_store) |-> (word_count < 6'(`WORDS_PER_LINE)));

endmodule

/* source/palette_color.sv */
`timescale 1ns/1ps
`include "display_consts.svh"

module palette_color (
  input  logic                   clock,
  input  logic                   reset,
  input  logic [9:0]             draw_x,
  input  logic                   active,
  input  logic                   hsync_raw,
  input  logic                   vsync_raw,
  input  display_pkg::mem_word_t line_word,
  output logic [11:0]            rgb,
  output logic                   hsync,
  output logic                   vsync
);

  localparam int LANE_BITS = $clog2(`PIXELS_PER_WORD);

  logic [LANE_BITS-1:0] lane_d;
  logic                 active_d;
  logic                 hsync_d;
  logic                 vsync_d;
  logic [7:0]           index;
  logic [11:0]          color;

  // This stage lines up with the registered buffer read.
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      active_d <= 1'b0;
      hsync_d  <= 1'b1;
      vsync_d  <= 1'b1;
    end
    else
    begin
      active_d <= active;
      hsync_d  <= hsync_raw;
      vsync_d  <= vsync_raw;
    end
  end

  always_ff @(posedge clock)
  begin
    lane_d <= draw_x[LANE_BITS-1:0];
  end

  assign index = line_word[lane_d * 8 +: 8];

  // Fixed palette: red and green from the nibbles, blue from their XOR.
  assign color = {index[7:4], index[3:0], index[7:4] ^ index[3:0]};

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      rgb   <= '0;
      hsync <= 1'b1;
      vsync <= 1'b1;
    end
    else
    begin
      rgb   <= active_d ? color : 12'h000;
      hsync <= hsync_d;
      vsync <= vsync_d;
    end
  end

  // A pixel outside the active area stays black after the full pipeline.
  a_blank: assert property (@(posedge clock) disable iff (reset)
    !$past(active, `PIPE_DELAY) |-> (rgb == 12'h000));

endmodule

/* source/scanline_display.sv */
`timescale 1ns/1ps

module scanline_display (
  input  logic                   clock,
  input  logic                   reset,
  output logic                   mem_read,
  output logic [21:0]            mem_address,
  input  display_pkg::mem_word_t mem_data,
  input  logic                   mem_ack,
  input  logic                   mem_wait,
  output logic [9:0]             draw_x,
  output logic [9:0]             draw_y,
  output logic [11:0]            rgb,
  output logic                   hsync,
  output logic                   vsync
);

  import display_pkg::*;

  logic      active;
  logic      new_frame;
  logic      hsync_raw;
  logic      vsync_raw;
  mem_word_t line_word;

  video_timing timing (
    .clock     (clock),
    .reset     (reset),
    .draw_x    (draw_x),
    .draw_y    (draw_y),
    .active    (active),
    .new_frame (new_frame),
    .hsync_raw (hsync_raw),
    .vsync_raw (vsync_raw)
  );

  // Reads one line ahead into the half of the line buffer not on screen.
  scanline_fetch fetch (
    .clock       (clock),
    .reset       (reset),
    .draw_x      (draw_x),
    .draw_y      (draw_y),
    .new_frame   (new_frame),
    .mem_read    (mem_read),
    .mem_address (mem_address),
    .mem_data    (mem_data),
    .mem_ack     (mem_ack),
    .mem_wait    (mem_wait),
    .line_word   (line_word)
  );

  palette_color palette (
    .clock     (clock),
    .reset     (reset),
    .draw_x    (draw_x),
    .active    (active),
    .hsync_raw (hsync_raw),
    .vsync_raw (vsync_raw),
    .line_word (line_word),
    .rgb       (rgb),
    .hsync     (hsync),
    .vsync     (vsync)
  );

endmodule

/* verification/scanline_display_tb.sv */
`timescale 1ns/1ps
`include "display_consts.svh"

module scanline_display_tb;

  import display_pkg::*;

  localparam int WAIT_LIMIT = 600000; // Longer than one full frame.
  localparam int PRINT_LIMIT = 20;

  typedef struct packed {
    int   frame;
    int   x;
    int   y;
    int   wait_len;
    logic image_b;
  } probe_t;

  logic        clock;
  logic        reset;
  logic        mem_read;
  logic [21:0] mem_address;
  mem_word_t   mem_data;
  logic        mem_ack;
  logic        mem_wait;
  logic [9:0]  draw_x;
  logic [9:0]  draw_y;
  logic [11:0] rgb;
  logic        hsync;
  logic        vsync;

  probe_t      probe_table [$];
  int          frame_count;
  int          value_errors;
  int          protocol_errors;
  int          timeouts;
  int          probes_checked;
  logic        busy;
  int          delay_left;
  int          history_count;
  int          x_d1;
  int          x_d2;
  int          y_d1;
  int          y_d2;
  int          ref_x;
  int          ref_y;
  logic        expect_hsync;
  logic        expect_vsync;

  scanline_display dut (
    .clock       (clock),
    .reset       (reset),
    .mem_read    (mem_read),
    .mem_address (mem_address),
    .mem_data    (mem_data),
    .mem_ack     (mem_ack),
    .mem_wait    (mem_wait),
    .draw_x      (draw_x),
    .draw_y      (draw_y),
    .rgb         (rgb),
    .hsync       (hsync),
    .vsync       (vsync)
  );

  always #10 clock = !clock;

  // Byte k of the word at address a holds the low byte of a plus 7k.
  function automatic mem_word_t memory_word(input logic [21:0] address);
    mem_word_t word;
    int        k;
    word = '0;
    for (k = 0; k < `PIXELS_PER_WORD; k++)
      word[k*8 +: 8] = address[7:0] + 8'(7 * k);
    return word;
  endfunction

  function automatic logic [11:0] expected_rgb(input int x, input int y, input logic image_b);
    logic [21:0] address;
    logic [7:0]  index;
    if ((x >= `H_ACTIVE) || (y >= `V_ACTIVE))
      return 12'h000;
    address = (image_b ? `FRAME_BASE_B : `FRAME_BASE_A)
              + 22'(y * `WORDS_PER_LINE + x / `PIXELS_PER_WORD);
    index = address[7:0] + 8'(7 * (x % `PIXELS_PER_WORD));
    return {index[7:4], index[3:0], index[7:4] ^ index[3:0]};
  endfunction

  task automatic add_probe(input int frame, input int x, input int y, input int wait_len,
                           input logic image_b);
    probe_t entry;
    entry.frame    = frame;
    entry.x        = x;
    entry.y        = y;
    entry.wait_len = wait_len;
    entry.image_b  = image_b;
    probe_table.push_back(entry);
  endtask

  // Moves a raster point forward by the pipeline delay, across line and frame wraps.
  task automatic advance_point(input int frame, input int x, input int y,
                               output int frame_out, output int x_out, output int y_out);
    int step;
    frame_out = frame;
    x_out     = x;
    y_out     = y;
    for (step = 0; step < `PIPE_DELAY; step++)
    begin
      x_out = x_out + 1;
      if (x_out == `H_TOTAL)
      begin
        x_out = 0;
        y_out = y_out + 1;
        if (y_out == `V_TOTAL)
        begin
          y_out     = 0;
          frame_out = frame_out + 1;
        end
      end
    end
  endtask

  task automatic wait_position(input int frame, input int x, input int y,
                               output logic timed_out);
    int   cycles;
    logic found;
    cycles = 0;
    found  = 1'b0;
    while (!found && (cycles < WAIT_LIMIT))
    begin
      @(negedge clock);
      cycles++;
      found = (frame_count == frame) && (int'(draw_x) == x) && (int'(draw_y) == y);
    end
    timed_out = !found;
    if (timed_out)
      $display("Timeout: the raster never reached frame %0d, x %0d, y %0d", frame, x, y);
  endtask

  task automatic check_probe(input int number, input probe_t entry);
    logic [11:0] expected;
    expected = expected_rgb(entry.x, entry.y, entry.image_b);
    probes_checked++;
    if (rgb !== expected)
    begin
      value_errors++;
      $display("Fail at %0t: probe %0d (frame %0d, x %0d, y %0d) gave rgb %h, expected %h",
               $time, number, entry.frame, entry.x, entry.y, rgb, expected);
    end
  endtask

  // The memory model answers each read after 1 to 6 cycles.
  always @(posedge clock)
  begin
    #1;
    if (reset)
    begin
      mem_ack = 1'b0;
      busy    = 1'b0;
    end
    else if (mem_ack)
    begin
      mem_ack = 1'b0;
      busy    = 1'b0;
    end
    else if (mem_read)
    begin
      if (!busy)
      begin
        busy       = 1'b1;
        delay_left = 1 + int'($urandom % 6);
      end
      delay_left = delay_left - 1;
      if (delay_left == 0)
      begin
        mem_data = memory_word(mem_address);
        mem_ack  = 1'b1;
      end
    end
  end

  always @(posedge clock)
  begin
    if (reset)
      frame_count <= 0;
    else if ((draw_x == 10'(`H_TOTAL - 1)) && (draw_y == 10'(`V_TOTAL - 1)))
      frame_count <= frame_count + 1;
  end

  // Syncs follow the coordinates of PIPE_DELAY cycles before.
  always @(negedge clock)
  begin
    if (reset)
    begin
      history_count = 0;
      ref_x         = 0;
      ref_y         = 0;
    end
    else
    begin
      // The raster starts at 0, 0 and steps one pixel per clock.
      if ((draw_x !== 10'(ref_x)) || (draw_y !== 10'(ref_y)))
      begin
        value_errors++;
        if (value_errors <= PRINT_LIMIT)
          $display("Fail at %0t: raster at x %0d y %0d, expected x %0d y %0d", $time,
                   draw_x, draw_y, ref_x, ref_y);
      end
      ref_x = ref_x + 1;
      if (ref_x == `H_TOTAL)
      begin
        ref_x = 0;
        ref_y = (ref_y == `V_TOTAL - 1) ? 0 : ref_y + 1;
      end
      if (mem_read && mem_wait)
      begin
        protocol_errors++;
        if (protocol_errors <= PRINT_LIMIT)
          $display("Fail at %0t: mem_read is high while mem_wait is high", $time);
      end
      if (history_count >= `PIPE_DELAY)
      begin
        expect_hsync = !((x_d2 >= `H_SYNC_START) && (x_d2 < `H_SYNC_END));
        expect_vsync = !((y_d2 >= `V_SYNC_START) && (y_d2 < `V_SYNC_END));
        if ((hsync !== expect_hsync) || (vsync !== expect_vsync))
        begin
          value_errors++;
          if (value_errors <= PRINT_LIMIT)
            $display("Fail at %0t: syncs %b%b for x %0d y %0d, expected %b%b", $time,
                     hsync, vsync, x_d2, y_d2, expect_hsync, expect_vsync);
        end
      end
      else
      begin
        history_count++;
      end
      x_d2 = x_d1;
      y_d2 = y_d1;
      x_d1 = int'(draw_x);
      y_d1 = int'(draw_y);
    end
  end

  initial
  begin
    probe_t entry;
    int     i;
    int     lane;
    int     frame_at;
    int     x_at;
    int     y_at;
    logic   timed_out;

    clock           = 1'b0;
    reset           = 1'b1;
    mem_ack         = 1'b0;
    mem_wait        = 1'b0;
    mem_data        = '0;
    busy            = 1'b0;
    delay_left      = 0;
    history_count   = 0;
    value_errors    = 0;
    protocol_errors = 0;
    timeouts        = 0;
    probes_checked  = 0;
    timed_out       = 1'b0;
    void'($urandom(32'h2179));

    // Frame 1 shows image B.
    add_probe(1, 0, 0, 0, 1'b1);
    add_probe(1, 1, 0, 0, 1'b1);
    add_probe(1, 639, 0, 0, 1'b1);
    add_probe(1, 640, 0, 0, 1'b1);
    for (lane = 0; lane < `PIXELS_PER_WORD; lane++)
      add_probe(1, 320 + lane, 7, 0, 1'b1);
    add_probe(1, 15, 100, 300, 1'b1);
    add_probe(1, 16, 100, 0, 1'b1);
    add_probe(1, 400, 100, 0, 1'b1);
    add_probe(1, 639, 100, 0, 1'b1);
    add_probe(1, 0, 479, 0, 1'b1);
    add_probe(1, 639, 479, 0, 1'b1);
    add_probe(1, 5, 480, 0, 1'b1);
    add_probe(1, 100, 520, 0, 1'b1);
    // Frame 2 is back on image A.
    add_probe(2, 0, 0, 0, 1'b0);
    add_probe(2, 17, 1, 0, 1'b0);
    add_probe(2, 333, 240, 400, 1'b0);
    add_probe(2, 334, 240, 0, 1'b0);
    add_probe(2, 639, 479, 0, 1'b0);
    add_probe(2, 700, 479, 0, 1'b0);
    add_probe(2, 0, 481, 0, 1'b0);

    repeat (9) @(posedge clock);
    @(negedge clock);
    if ((mem_read !== 1'b0) || (rgb !== 12'h000) || (hsync !== 1'b1) || (vsync !== 1'b1))
    begin
      value_errors++;
      $display("Fail at %0t: outputs during reset mem_read %b rgb %h hsync %b vsync %b",
               $time, mem_read, rgb, hsync, vsync);
    end
    if (dut.fetch.state !== fetch_idle)
    begin
      value_errors++;
      $display("Fail at %0t: fetch state is not idle during reset", $time);
    end
    @(posedge clock);
    #1;
    reset = 1'b0;

    for (i = 0; (i < probe_table.size()) && !timed_out; i++)
    begin
      entry = probe_table[i];
      if (entry.wait_len != 0)
      begin
        // Hold mem_wait from the first pixel of the line that fetches the probed line.
        wait_position(entry.frame, `H_TOTAL - 1, entry.y - 2, timed_out);
        if (!timed_out)
        begin
          @(posedge clock);
          #1;
          mem_wait = 1'b1;
          repeat (entry.wait_len) @(posedge clock);
          #1;
          mem_wait = 1'b0;
        end
      end
      if (!timed_out)
      begin
        advance_point(entry.frame, entry.x, entry.y, frame_at, x_at, y_at);
        wait_position(frame_at, x_at, y_at, timed_out);
        if (!timed_out)
          check_probe(i, entry);
      end
    end
    if (timed_out)
      timeouts++;

    $display("Summary: %0d probes checked, %0d value errors, %0d protocol errors, %0d timeouts",
             probes_checked, value_errors, protocol_errors, timeouts);
    if ((value_errors == 0) && (protocol_errors == 0) && (timeouts == 0))
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

/* compile.f */
+incdir+source
source/display_pkg.sv
source/video_timing.sv
source/scanline_fetch.sv
source/palette_color.sv
source/scanline_display.sv
verification/scanline_display_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.
set -e

cd "$(dirname "$0")"
mkdir -p build

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f compile.f \
  --top-module scanline_display_tb \
  -Mdir build/obj_dir \
  -o scanline_display_sim

./build/obj_dir/scanline_display_sim | tee build/sim.log

if grep -q "All tests passed!" build/sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi
